//--- simple_axi_write.f
common/axi_write_pkg.sv
hdl/write_burst_planner.sv
hdl/write_data_aligner.sv
hdl/simple_axi_write.sv
tests/axi_slave_model.sv
tests/tb_simple_axi_write.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_simple_axi_write -f simple_axi_write.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
   echo "Simulation result: pass"
else
   echo "Simulation result: fail"
   exit 1
fi

//--- tests/tb_simple_axi_write.sv
`timescale 1ns/100ps

module tb_simple_axi_write;
   import axi_write_pkg::*;

   localparam int n_rows     = 11;
   localparam int mem_bytes  = 8192;
   localparam int max_cycles = 3000;

   logic                  clk;
   logic                  rst;
   logic                  m_wvalid;
   logic                  m_wready;
   logic [AXI_ADDR_W-1:0] m_waddr;
   logic [AXI_DATA_W-1:0] m_wdata;
   logic [LEN_W-1:0]      m_wlen;
   logic                  m_wlast;
   logic [AXI_ADDR_W-1:0] m_axi_awaddr;
   logic [AXLEN_W-1:0]    m_axi_awlen;
   logic                  m_axi_awvalid;
   logic                  m_axi_awready;
   logic [AXI_DATA_W-1:0] m_axi_wdata;
   logic [STRB_W-1:0]     m_axi_wstrb;
   logic                  m_axi_wlast;
   logic                  m_axi_wvalid;
   logic                  m_axi_wready;
   logic                  throttle;

   // Start address, length in bytes, ready throttling
   int unsigned row_addr [n_rows] = '{'h100, 'h201, 'h302, 'h403, 'h521, 'h731,
                                      'h800, 'hFD6, 'h1203, 'hFF1, 'h100};
   int          row_len  [n_rows] = '{64, 1, 3, 5, 37, 36, 200, 120, 150, 77, 64};
   bit          row_thr  [n_rows] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1};

   logic [7:0]            exp_mem [mem_bytes];
   logic [31:0]           words [$];
   logic [AXI_ADDR_W-1:0] exp_addr_q [$];
   logic [AXLEN_W-1:0]    exp_len_q [$];
   logic [15:0]           lfsr;
   int                    rec_base;

   simple_axi_write DUT (.*);

   axi_slave_model slave (
      .clk      (clk),
      .rst      (rst),
      .throttle (throttle),
      .awaddr   (m_axi_awaddr),
      .awlen    (m_axi_awlen),
      .awvalid  (m_axi_awvalid),
      .awready  (m_axi_awready),
      .wdata    (m_axi_wdata),
      .wstrb    (m_axi_wstrb),
      .wlast    (m_axi_wlast),
      .wvalid   (m_axi_wvalid),
      .wready   (m_axi_wready)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] next_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         w    = {w[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return w;
   endfunction

   // Bursts of at most 16 beats, cut at every 4 KB page
   function automatic void plan_bursts(input int unsigned addr, input int len);
      int unsigned a;
      int          rem;
      int          n;
      int          to_edge;
      exp_addr_q.delete();
      exp_len_q.delete();
      a   = addr & ~32'd3;
      rem = ((addr % 4) + len + 3) / 4;
      while (rem > 0) begin
         n       = rem < 16 ? rem : 16;
         to_edge = (4096 - (a % 4096)) / 4;
         if (n > to_edge)
            n = to_edge;
         exp_addr_q.push_back(a);
         exp_len_q.push_back(AXLEN_W'(n - 1));
         a   = a + 4 * n;
         rem = rem - n;
      end
   endfunction

   task automatic abort_run();
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
      if (got !== expected) begin
         $display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
         abort_run();
      end
   endtask

   task automatic run_transfer(input int unsigned addr, input int len, input bit thr);
      int n_words;
      int idx;
      int cyc;
      int aw_rise;
      int wlast_cnt;
      bit hs;
      bit done;
      words.delete();
      n_words = (len + 3) / 4;
      for (int i = 0; i < n_words; i++)
         words.push_back(next_word());
      for (int k = 0; k < len; k++)
         exp_mem[(addr + k) % mem_bytes] = words[k / 4][8 * (k % 4) +: 8];
      plan_bursts(addr, len);

      @(posedge clk);
      #2;
      throttle = thr;
      m_waddr  = addr;
      m_wlen   = LEN_W'(len);
      m_wdata  = words[0];
      m_wvalid = 1'b1;
      idx       = 0;
      cyc       = 0;
      aw_rise   = -1;
      wlast_cnt = 0;
      done      = 1'b0;
      while (!done) begin
         @(negedge clk);   // Handshakes settle mid cycle
         hs = m_wvalid && m_wready;
         if (m_axi_awvalid && aw_rise < 0)
            aw_rise = cyc;
         if (m_wlast) begin
            wlast_cnt++;
            done = 1'b1;
         end
         @(posedge clk);
         #2;
         if (hs) begin
            idx++;
            if (idx < n_words)
               m_wdata = words[idx];
            else
               m_wvalid = 1'b0;
         end
         cyc++;
         if (cyc > max_cycles) begin
            $display("Timed out waiting for the end of the transfer at 0x%h", addr);
            abort_run();
         end
      end
      repeat (3) begin
         @(negedge clk);
         if (m_wlast)
            wlast_cnt++;
      end
      compare("m_wlast pulses", wlast_cnt, 1);
      compare("user words", idx, n_words);
      compare("awvalid delay", aw_rise, 2);
   endtask

   task automatic check_memory();
      for (int a = 0; a < mem_bytes; a++)
         compare($sformatf("mem[%04h]", a), slave.mem[a], exp_mem[a]);
   endtask

   task automatic check_bursts();
      compare("aw count", slave.aw_addr_q.size() - rec_base, exp_addr_q.size());
      for (int i = 0; i < exp_addr_q.size(); i++) begin
         compare("m_axi_awaddr", slave.aw_addr_q[rec_base + i], exp_addr_q[i]);
         compare("m_axi_awlen", slave.aw_len_q[rec_base + i], exp_len_q[i]);
      end
      rec_base += exp_addr_q.size();
   endtask

   initial begin
      rst      = 1'b1;
      m_wvalid = 1'b0;
      m_waddr  = '0;
      m_wdata  = '0;
      m_wlen   = '0;
      throttle = 1'b0;
      lfsr     = 16'd79;
      rec_base = 0;
      repeat (8) @(posedge clk);
      #2 rst = 1'b0;
      @(negedge clk);
      compare("m_axi_awvalid", m_axi_awvalid, 0);
      compare("m_axi_wvalid", m_axi_wvalid, 0);
      compare("m_axi_wlast", m_axi_wlast, 0);
      compare("m_wready", m_wready, 0);
      compare("m_wlast", m_wlast, 0);
      compare("slave size_ok", slave.size_ok, 1);
      for (int a = 0; a < mem_bytes; a++)
         exp_mem[a] = slave.mem[a];   // Slave's fill pattern

      for (int r = 0; r < n_rows; r++) begin
         run_transfer(row_addr[r], row_len[r], row_thr[r]);
         check_memory();
         check_bursts();
      end
      compare("slave wlast_err", slave.wlast_err, 0);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- tests/axi_slave_model.sv
`timescale 1ns/100ps

module axi_slave_model
   import axi_write_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  throttle,
   input  logic [AXI_ADDR_W-1:0] awaddr,
   input  logic [AXLEN_W-1:0]    awlen,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [AXI_DATA_W-1:0] wdata,
   input  logic [STRB_W-1:0]     wstrb,
   input  logic                  wlast,
   input  logic                  wvalid,
   output logic                  wready
);

   localparam int         mem_bytes  = 8192;
   localparam logic [1:0] burst_type = AXI_BURST_INCR;   // No burst port, INCR assumed

   logic [7:0]            mem [mem_bytes];
   logic [AXI_ADDR_W-1:0] aw_addr_q [$];
   logic [AXLEN_W-1:0]    aw_len_q [$];
   logic [AXI_ADDR_W-1:0] w_addr;
   logic [AXLEN_W-1:0]    w_len;
   logic [AXLEN_W-1:0]    w_beat;
   logic [15:0]           lfsr;
   logic [15:0]           lfsr_mid;
   logic                  size_ok;
   int                    wlast_err;

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // Word beats only
   assign size_ok  = (1 << AXI_SIZE_WORD) == STRB_W;
   assign lfsr_mid = lfsr_step(lfsr);

   initial begin
      for (int a = 0; a < mem_bytes; a++)
         mem[a] = 8'((a * 13) ^ (a >> 7));
   end

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         awready   <= 1'b0;
         wready    <= 1'b0;
         lfsr      <= 16'd79;
         w_addr    <= '0;
         w_len     <= '0;
         w_beat    <= '0;
         wlast_err <= 0;
      end else begin
         if (throttle) begin
            awready <= lfsr[0];       // One LFSR step per ready bit
            wready  <= lfsr_mid[0];
            lfsr    <= lfsr_step(lfsr_mid);
         end else begin
            awready <= 1'b1;
            wready  <= 1'b1;
         end

         if (wvalid && wready) begin
            for (int i = 0; i < STRB_W; i++) begin
               if (wstrb[i])
                  mem[w_addr[12:0] + 13'(i)] <= wdata[8*i +: 8];
            end
            if (wlast != (w_beat == w_len))
               wlast_err <= wlast_err + 1;
            if (burst_type == AXI_BURST_INCR)
               w_addr <= w_addr + (AXI_ADDR_W'(1) << AXI_SIZE_WORD);
            w_beat <= w_beat + 1'b1;
         end

         if (awvalid && awready) begin
            aw_addr_q.push_back(awaddr);
            aw_len_q.push_back(awlen);
            w_addr <= awaddr;
            w_len  <= awlen;
            w_beat <= '0;
         end
      end
   end

endmodule

//--- hdl/simple_axi_write.sv
`timescale 1ns/100ps

module simple_axi_write
   import axi_write_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,

   input  logic                  m_wvalid,
   output logic                  m_wready,
   input  logic [AXI_ADDR_W-1:0] m_waddr,
   input  logic [AXI_DATA_W-1:0] m_wdata,
   input  logic [LEN_W-1:0]      m_wlen,
   output logic                  m_wlast,

   output logic [AXI_ADDR_W-1:0] m_axi_awaddr,
   output logic [AXLEN_W-1:0]    m_axi_awlen,
   output logic                  m_axi_awvalid,
   input  logic                  m_axi_awready,
   output logic [AXI_DATA_W-1:0] m_axi_wdata,
   output logic [STRB_W-1:0]     m_axi_wstrb,
   output logic                  m_axi_wlast,
   output logic                  m_axi_wvalid,
   input  logic                  m_axi_wready
);

   enum logic [1:0] {ST_IDLE, ST_LATCH, ST_ADDR, ST_DATA} state;

   logic                  start;
   logic                  aw_hs;
   logic                  w_hs;
   logic                  user_hs;
   logic                  hold_off;      // Gap cycle after a transfer
   logic                  first_q;       // Next beat is the transfer's first
   logic                  last_burst_q;
   logic [AXLEN_W-1:0]    beat_cnt;
   logic                  last_beat;
   logic                  final_beat;
   logic                  flush;
   logic                  aw_open;       // Burst address accepted

   logic [AXI_ADDR_W-1:0] burst_addr;
   logic [AXLEN_W-1:0]    burst_len;
   logic [STRB_W-1:0]     first_strb;
   logic [STRB_W-1:0]     final_strb;
   logic                  last_burst;
   logic                  extra_beat;

   assign start   = state == ST_IDLE && m_wvalid && !hold_off;
   assign aw_hs   = m_axi_awvalid && m_axi_awready;
   assign w_hs    = m_axi_wvalid && m_axi_wready;
   assign user_hs = m_wvalid && m_wready;

   write_burst_planner planner (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .next_burst (aw_hs),
      .address    (m_waddr),
      .length     (m_wlen),
      .burst_addr (burst_addr),
      .burst_len  (burst_len),
      .first_strb (first_strb),
      .final_strb (final_strb),
      .last_burst (last_burst),
      .extra_beat (extra_beat)
   );

   write_data_aligner aligner (
      .clk        (clk),
      .rst        (rst),
      .load       (start),
      .data_valid (user_hs),
      .offset     (m_waddr[OFFSET_W-1:0]),
      .data_in    (m_wdata),
      .data_out   (m_axi_wdata)
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state         <= ST_IDLE;
         m_axi_awvalid <= 1'b0;
         m_axi_awaddr  <= '0;
         m_axi_awlen   <= '0;
         last_burst_q  <= 1'b0;
         first_q       <= 1'b0;
         beat_cnt      <= '0;
         hold_off      <= 1'b0;
      end else begin
         hold_off <= w_hs && final_beat;

         case (state)
            ST_IDLE: begin
               if (start) begin
                  first_q <= 1'b1;
                  state   <= ST_LATCH;
               end
            end
            ST_LATCH: begin   // Planner fields are valid here
               m_axi_awaddr  <= burst_addr;
               m_axi_awlen   <= burst_len;
               last_burst_q  <= last_burst;
               m_axi_awvalid <= 1'b1;
               state         <= ST_ADDR;
            end
            ST_ADDR: begin
               if (m_axi_awready) begin
                  m_axi_awvalid <= 1'b0;
                  beat_cnt      <= '0;
                  state         <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (w_hs) begin
                  first_q  <= 1'b0;
                  beat_cnt <= beat_cnt + 1'b1;
                  if (last_beat)
                     state <= last_burst_q ? ST_IDLE : ST_LATCH;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign last_beat  = beat_cnt == m_axi_awlen;
   assign final_beat = state == ST_DATA && last_beat && last_burst_q;
   assign flush      = final_beat && extra_beat;   // No user word behind it

   assign m_axi_wvalid = state == ST_DATA && (m_wvalid || flush);
   assign m_axi_wlast  = state == ST_DATA && last_beat;
   assign m_wready     = state == ST_DATA && m_axi_wready && !flush;
   assign m_wlast      = w_hs && final_beat;

   // Edge strobes, both on a single-beat transfer
   always_comb begin
      m_axi_wstrb = '1;
      if (first_q)
         m_axi_wstrb = m_axi_wstrb & first_strb;
      if (final_beat)
         m_axi_wstrb = m_axi_wstrb & final_strb;
   end

   // Open from the AW handshake until the wlast handshake
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         aw_open <= 1'b0;
      else if (aw_hs)
         aw_open <= 1'b1;
      else if (w_hs && m_axi_wlast)
         aw_open <= 1'b0;
   end

   aw_stable: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid && !m_axi_awready |=>
         m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen));

   // W of a burst only opens after its address is accepted
   w_after_aw: assert property (@(posedge clk) disable iff (rst)
      m_axi_wvalid |-> aw_open);

endmodule

//--- hdl/write_data_aligner.sv
`timescale 1ns/100ps

module write_data_aligner
   import axi_write_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  load,
   input  logic                  data_valid,
   input  logic [OFFSET_W-1:0]   offset,
   input  logic [AXI_DATA_W-1:0] data_in,
   output logic [AXI_DATA_W-1:0] data_out
);

   logic [OFFSET_W-1:0]     offset_q;
   logic [AXI_DATA_W-1:0]   held;      // Spill of the previous word
   logic [2*AXI_DATA_W-1:0] shifted;

   // Word moved up by the offset, top bytes spill into the next beat
   assign shifted  = {{AXI_DATA_W{1'b0}}, data_in} << {offset_q, 3'b000};
   assign data_out = shifted[AXI_DATA_W-1:0] | held;

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         offset_q <= '0;
      else if (load)
         offset_q <= offset;
   end

   // Kept across a flush beat, so the tail goes out without new data
   always_ff @(posedge clk) begin
      if (load)
         held <= '0;
      else if (data_valid)
         held <= shifted[2*AXI_DATA_W-1:AXI_DATA_W];
   end

endmodule

//--- hdl/write_burst_planner.sv
`timescale 1ns/100ps

module write_burst_planner
   import axi_write_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  logic                  next_burst,
   input  logic [AXI_ADDR_W-1:0] address,
   input  logic [LEN_W-1:0]      length,
   output logic [AXI_ADDR_W-1:0] burst_addr,
   output logic [AXLEN_W-1:0]    burst_len,
   output logic [STRB_W-1:0]     first_strb,
   output logic [STRB_W-1:0]     final_strb,
   output logic                  last_burst,
   output logic                  extra_beat
);

   logic [OFFSET_W-1:0]   offset;
   logic [LEN_W:0]        end_bytes;    // Offset plus length
   logic [OFFSET_W-1:0]   end_off;
   logic [BEATS_W-1:0]    total_beats;
   logic [BEATS_W-1:0]    word_beats;   // Words the user supplies
   logic [STRB_W-1:0]     all_lanes;
   logic [AXI_ADDR_W-1:0] nxt_addr;
   logic [BEATS_W-1:0]    nxt_remaining;
   logic [BEATS_W-1:0]    remaining;
   logic [BEATS_W-1:0]    burst_beats;
   logic [BEATS_W-1:0]    to_boundary;
   logic [BEATS_W-1:0]    beats;
   logic [BOUNDARY_W:0]   burst_end;

   assign all_lanes   = '1;
   assign offset      = address[OFFSET_W-1:0];
   assign end_bytes   = (LEN_W+1)'(offset) + (LEN_W+1)'(length);
   assign end_off     = end_bytes[OFFSET_W-1:0];
   assign total_beats = BEATS_W'((end_bytes + (LEN_W+1)'(STRB_W-1)) >> OFFSET_W);
   assign word_beats  = BEATS_W'(({1'b0, length} + (LEN_W+1)'(STRB_W-1)) >> OFFSET_W);
   assign burst_beats = BEATS_W'(burst_len) + 1'b1;

   // Next burst start and what is left of the transfer
   always_comb begin
      if (start) begin
         nxt_addr      = {address[AXI_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
         nxt_remaining = total_beats;
      end else begin
         nxt_addr      = burst_addr + AXI_ADDR_W'({burst_beats, {OFFSET_W{1'b0}}});
         nxt_remaining = remaining - burst_beats;
      end

      to_boundary = BEATS_W'(BOUNDARY_BEATS)
                  - BEATS_W'(nxt_addr[BOUNDARY_W-1:OFFSET_W]);

      // Smallest of remaining, burst limit, distance to 4 KB
      beats = nxt_remaining;
      if (beats > BEATS_W'(MAX_BURST_BEATS))
         beats = BEATS_W'(MAX_BURST_BEATS);
      if (beats > to_boundary)
         beats = to_boundary;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         burst_addr <= '0;
         remaining  <= '0;
         burst_len  <= '0;
         last_burst <= 1'b0;
         first_strb <= '0;
         final_strb <= '0;
         extra_beat <= 1'b0;
      end else begin
         if (start) begin
            first_strb <= all_lanes << offset;
            if (end_off == '0)
               final_strb <= all_lanes;
            else
               final_strb <= ~(all_lanes << end_off);
            extra_beat <= total_beats > word_beats;
         end

         // Fields stay put once the last burst is issued
         if (start || (next_burst && !last_burst)) begin
            burst_addr <= nxt_addr;
            remaining  <= nxt_remaining;
            burst_len  <= AXLEN_W'(beats - 1'b1);
            last_burst <= beats == nxt_remaining;
         end
      end
   end

   assign burst_end = (BOUNDARY_W+1)'(burst_addr[BOUNDARY_W-1:0])
                    + (BOUNDARY_W+1)'({burst_len, {OFFSET_W{1'b0}}})
                    + (BOUNDARY_W+1)'(STRB_W);

   burst_len_limit: assert property (@(posedge clk) disable iff (rst)
      burst_len < AXLEN_W'(MAX_BURST_BEATS));

   // Last byte of the burst stays inside its 4 KB page
   no_boundary_cross: assert property (@(posedge clk) disable iff (rst)
      burst_end <= (BOUNDARY_W+1)'(BOUNDARY_BYTES));

endmodule

//--- common/axi_write_pkg.sv
package axi_write_pkg;

   // Bus widths
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int STRB_W     = AXI_DATA_W / 8;
   localparam int OFFSET_W   = $clog2(STRB_W);

   // User length in bytes, AXI burst length field
   localparam int LEN_W   = 12;
   localparam int AXLEN_W = 8;

   // Burst limits
   localparam int MAX_BURST_BEATS = 16;
   localparam int BOUNDARY_BYTES  = 4096;
   localparam int BOUNDARY_W      = $clog2(BOUNDARY_BYTES);
   localparam int BOUNDARY_BEATS  = BOUNDARY_BYTES / STRB_W;

   // Beat count of a whole transfer, up to 1025 with a flush beat
   localparam int BEATS_W = LEN_W - OFFSET_W + 1;

   // AXI encodings assumed by the slave side
   localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;   // 4 bytes per beat
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

endpackage
